//--- logic/twdl_consts.svh
// ----------------------------------------------------------
// widths, amplitude and CORDIC sizing for the twiddle generator
// ----------------------------------------------------------
`ifndef TWDL_CONSTS_SVH
`define TWDL_CONSTS_SVH

// phase is a fraction of a full turn, 2^20 units per turn
`define TWDL_W_PHASE 20

// transform size N and the step remainder
`define TWDL_W_DEN 12

// signed output component
`define TWDL_W_OUT 16

// unit amplitude of cos / sin at the outputs
`define TWDL_AMP 16384

// start vector, amplitude over the CORDIC gain 1.647
`define TWDL_CORDIC_X0 9948

// fractional guard bits inside the CORDIC datapath
`define TWDL_W_GUARD 4

// shift-add micro-rotations
`define TWDL_STAGES 16

// phase register to output: fold + iterations + output reg
`define TWDL_LATENCY 18

`endif

//--- logic/twdl_pkg.sv
// ----------------------------------------------------------
// config opcodes, handshake states, phase and sample types
// ----------------------------------------------------------
`include "twdl_consts.svh"

package twdl_pkg;

	// config port opcodes
	typedef enum logic [2:0] {
		OP_SET_DEN = 3'd0,
		OP_SET_QUO = 3'd1,
		OP_SET_REM = 3'd2,
		OP_RUN     = 3'd3,
		OP_HALT    = 3'd4
	} twdl_op_e;

	// four-phase req/ack slave states
	typedef enum logic {
		CFG_IDLE  = 1'b0,
		CFG_ACKED = 1'b1
	} cfg_state_e;

	typedef logic [`TWDL_W_PHASE-1:0] phase_t;
	typedef logic [`TWDL_W_DEN-1:0] den_t;
	typedef logic signed [`TWDL_W_OUT-1:0] sample_t;

endpackage

//--- logic/twdl_cfg_regs.sv
// ----------------------------------------------------------
// req/ack config slave holding N, step quotient/remainder, run
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "twdl_consts.svh"

module twdl_cfg_regs (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     cfg_req,
	input  twdl_pkg::twdl_op_e       cfg_op,
	input  logic [`TWDL_W_PHASE-1:0] cfg_data,
	output logic                     cfg_ack,
	output twdl_pkg::den_t           den,
	output twdl_pkg::phase_t         step_quo,
	output twdl_pkg::den_t           step_rem,
	output logic                     run
);

	twdl_pkg::cfg_state_e state;
	logic write_en;

	// accept only from idle, so a req held high is not taken twice
	assign write_en = (state == twdl_pkg::CFG_IDLE) && cfg_req;
	assign cfg_ack = (state == twdl_pkg::CFG_ACKED);

	// ------------------------------------------------------------
	// handshake FSM
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= twdl_pkg::CFG_IDLE;
		end else begin
			case (state)
				twdl_pkg::CFG_IDLE: begin
					// ack one clock after req seen
					if (cfg_req)
						state <= twdl_pkg::CFG_ACKED;
				end
				default: begin
					// drop ack one clock after req falls
					if (!cfg_req)
						state <= twdl_pkg::CFG_IDLE;
				end
			endcase
		end
	end

	// ------------------------------------------------------------
	// field writes on entry to acked
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			den <= '0;
			step_quo <= '0;
			step_rem <= '0;
			run <= 1'b0;
		end else if (write_en) begin
			case (cfg_op)
				twdl_pkg::OP_SET_DEN: den <= cfg_data[`TWDL_W_DEN-1:0];
				twdl_pkg::OP_SET_QUO: step_quo <= cfg_data;
				twdl_pkg::OP_SET_REM: step_rem <= cfg_data[`TWDL_W_DEN-1:0];
				twdl_pkg::OP_RUN: run <= 1'b1;
				twdl_pkg::OP_HALT: run <= 1'b0;
				// unknown codes still get acked, nothing written
				default: ;
			endcase
		end
	end

	// ack only ever answers a req from the previous clock
	a_ack_after_req: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(cfg_ack) |-> $past(cfg_req));

	// remainder math needs a nonzero modulus once running
	a_run_needs_den: assert property (@(posedge clk) disable iff (!rst_n)
		run |-> (den != '0));

endmodule

//--- logic/cordic_rotator.sv
// ----------------------------------------------------------
// pipelined rotation-mode CORDIC, quadrant fold and valid pipe
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "twdl_consts.svh"

module cordic_rotator (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                in_valid,
	input  twdl_pkg::phase_t    phase,
	output logic                out_valid,
	output twdl_pkg::sample_t   cos_out,
	output twdl_pkg::sample_t   sin_out
);

	localparam int STAGES = `TWDL_STAGES;
	localparam int LATENCY = `TWDL_LATENCY;
	localparam int GUARD = `TWDL_W_GUARD;
	// amplitude plus guard bits plus headroom for the gain
	localparam int W_XY = `TWDL_W_OUT + GUARD + 2;
	// residual angle, signed, in phase units
	localparam int W_Z = `TWDL_W_PHASE + 1;

	localparam logic signed [W_XY-1:0] X_START = W_XY'(`TWDL_CORDIC_X0 << GUARD);
	localparam logic signed [W_XY-1:0] HALF_LSB = W_XY'(1 << (GUARD - 1));

	// atan(2^-i) in units of 2^-20 turn
	localparam logic signed [W_Z-1:0] ATAN [0:STAGES-1] = '{
		131072, 77376, 40884, 20753, 10417, 5213, 2607, 1304,
		652, 326, 163, 81, 41, 20, 10, 5
	};

	// index 0 is the fold register, index k the result of iteration k-1
	logic signed [W_XY-1:0] x_pipe [0:STAGES];
	logic signed [W_XY-1:0] y_pipe [0:STAGES];
	logic signed [W_Z-1:0] z_pipe [0:STAGES];
	logic [1:0] quad_pipe [0:STAGES];
	logic [LATENCY-1:0] valid_pipe;

	// rounded first-quadrant results
	logic signed [W_XY-1:0] x_rnd;
	logic signed [W_XY-1:0] y_rnd;
	twdl_pkg::sample_t c_q;
	twdl_pkg::sample_t s_q;

	// ------------------------------------------------------------
	// fold and micro-rotations
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		// top two bits pick the quadrant, rest is in [0, 90 deg)
		x_pipe[0] <= X_START;
		y_pipe[0] <= '0;
		z_pipe[0] <= {{(W_Z - `TWDL_W_PHASE + 2){1'b0}}, phase[`TWDL_W_PHASE-3:0]};
		quad_pipe[0] <= phase[`TWDL_W_PHASE-1:`TWDL_W_PHASE-2];

		for (int i = 0; i < STAGES; i++) begin
			// drive residual toward zero
			if (!z_pipe[i][W_Z-1]) begin
				x_pipe[i+1] <= x_pipe[i] - (y_pipe[i] >>> i);
				y_pipe[i+1] <= y_pipe[i] + (x_pipe[i] >>> i);
				z_pipe[i+1] <= z_pipe[i] - ATAN[i];
			end else begin
				x_pipe[i+1] <= x_pipe[i] + (y_pipe[i] >>> i);
				y_pipe[i+1] <= y_pipe[i] - (x_pipe[i] >>> i);
				z_pipe[i+1] <= z_pipe[i] + ATAN[i];
			end
			quad_pipe[i+1] <= quad_pipe[i];
		end
	end

	// valid rides alongside, last bit is the output register
	always_ff @(posedge clk) begin
		if (!rst_n)
			valid_pipe <= '0;
		else
			valid_pipe <= {valid_pipe[LATENCY-2:0], in_valid};
	end

	// ------------------------------------------------------------
	// round off guard bits, undo the quadrant fold
	// ------------------------------------------------------------
	assign x_rnd = (x_pipe[STAGES] + HALF_LSB) >>> GUARD;
	assign y_rnd = (y_pipe[STAGES] + HALF_LSB) >>> GUARD;
	assign c_q = x_rnd[`TWDL_W_OUT-1:0];
	assign s_q = y_rnd[`TWDL_W_OUT-1:0];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cos_out <= '0;
			sin_out <= '0;
		end else if (valid_pipe[STAGES]) begin
			// hold last sample between bursts
			case (quad_pipe[STAGES])
				2'd0: begin
					cos_out <= c_q;
					sin_out <= s_q;
				end
				2'd1: begin
					cos_out <= -s_q;
					sin_out <= c_q;
				end
				2'd2: begin
					cos_out <= -c_q;
					sin_out <= -s_q;
				end
				default: begin
					cos_out <= s_q;
					sin_out <= -c_q;
				end
			endcase
		end
	end

	assign out_valid = valid_pipe[LATENCY-1];

endmodule

//--- logic/coeff_twdl.sv
// ----------------------------------------------------------
// mixed-radix phase accumulator feeding the CORDIC, conj output
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "twdl_consts.svh"

module coeff_twdl (
	input  logic                clk,
	input  logic                rst_n,
	input  twdl_pkg::den_t      den,
	input  twdl_pkg::phase_t    step_quo,
	input  twdl_pkg::den_t      step_rem,
	input  logic                run,
	output logic                out_valid,
	output twdl_pkg::sample_t   dout_real,
	output twdl_pkg::sample_t   dout_imag
);

	// exact phase is acc_quo + acc_rem/den in turn units
	twdl_pkg::phase_t acc_quo;
	twdl_pkg::den_t acc_rem;
	twdl_pkg::phase_t quo_next;
	twdl_pkg::den_t rem_next;
	// one extra bit so the remainder sum cannot wrap
	logic [`TWDL_W_DEN:0] rem_sum;
	logic [`TWDL_W_DEN:0] rem_diff;
	logic carry;

	// registered CORDIC input
	twdl_pkg::phase_t phase_q;
	logic valid_q;

	twdl_pkg::sample_t cos_out;
	twdl_pkg::sample_t sin_out;

	// ------------------------------------------------------------
	// modulo-N remainder, carry into the quotient
	// ------------------------------------------------------------
	assign rem_sum = {1'b0, acc_rem} + {1'b0, step_rem};
	assign rem_diff = rem_sum - {1'b0, den};
	assign carry = (rem_sum >= {1'b0, den});
	assign rem_next = carry ? rem_diff[`TWDL_W_DEN-1:0] : rem_sum[`TWDL_W_DEN-1:0];
	// quotient wraps mod one turn
	assign quo_next = acc_quo + step_quo + {{(`TWDL_W_PHASE-1){1'b0}}, carry};

	always_ff @(posedge clk) begin
		if (!rst_n || !run) begin
			// halted: restart from phase 0 on next run
			acc_quo <= '0;
			acc_rem <= '0;
		end else begin
			acc_quo <= quo_next;
			acc_rem <= rem_next;
		end
	end

	// sample n enters the rotator one clock after the accumulator holds it
	always_ff @(posedge clk) begin
		if (!rst_n)
			valid_q <= 1'b0;
		else
			valid_q <= run;
	end

	always_ff @(posedge clk) begin
		phase_q <= acc_quo;
	end

	cordic_rotator u_cordic (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (valid_q),
		.phase     (phase_q),
		.out_valid (out_valid),
		.cos_out   (cos_out),
		.sin_out   (sin_out)
	);

	// exp(-j*theta): conjugate by flipping the sine
	assign dout_real = cos_out;
	assign dout_imag = -sin_out;

	// remainder is a proper residue mod N for as long as we run
	a_rem_below_den: assert property (@(posedge clk) disable iff (!rst_n)
		run |-> (acc_rem < den));

endmodule

//--- logic/twdl_gen_top.sv
// ----------------------------------------------------------
// top level, config slave plus twiddle generator
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "twdl_consts.svh"

module twdl_gen_top (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     cfg_req,
	input  twdl_pkg::twdl_op_e       cfg_op,
	input  logic [`TWDL_W_PHASE-1:0] cfg_data,
	output logic                     cfg_ack,
	output logic                     out_valid,
	output twdl_pkg::sample_t        dout_real,
	output twdl_pkg::sample_t        dout_imag
);

	// held config, changes one clock after its write
	twdl_pkg::den_t den;
	twdl_pkg::phase_t step_quo;
	twdl_pkg::den_t step_rem;
	logic run;

	twdl_cfg_regs u_cfg (
		.clk      (clk),
		.rst_n    (rst_n),
		.cfg_req  (cfg_req),
		.cfg_op   (cfg_op),
		.cfg_data (cfg_data),
		.cfg_ack  (cfg_ack),
		.den      (den),
		.step_quo (step_quo),
		.step_rem (step_rem),
		.run      (run)
	);

	// run rise to first out_valid is 19 clocks
	coeff_twdl u_twdl (
		.clk       (clk),
		.rst_n     (rst_n),
		.den       (den),
		.step_quo  (step_quo),
		.step_rem  (step_rem),
		.run       (run),
		.out_valid (out_valid),
		.dout_real (dout_real),
		.dout_imag (dout_imag)
	);

endmodule

//--- testbench/twdl_tb_checks.svh
// ----------------------------------------------------------
// typed compare tasks, reference model and error counters
// ----------------------------------------------------------
`ifndef TWDL_TB_CHECKS_SVH
`define TWDL_TB_CHECKS_SVH

string cur_test;
int error_count;
int check_total;
int test_mark;
int tests_run;
int tests_failed;

localparam real TWO_PI = 6.283185307179586;

// component match within +/- 6 LSB
task automatic check_sample(input twdl_pkg::sample_t expected, input twdl_pkg::sample_t actual);
	int diff;
	diff = int'(actual) - int'(expected);
	check_total++;
	if (diff > 6 || diff < -6) begin
		error_count++;
		$display("FAIL %s: expected %0d, actual %0d", cur_test, expected, actual);
	end
endtask

task automatic check_flag(input logic expected, input logic actual);
	check_total++;
	if (actual !== expected) begin
		error_count++;
		$display("FAIL %s: expected flag %b, actual %b", cur_test, expected, actual);
	end
endtask

// handshake latencies in clocks
task automatic check_count(input int expected, input int actual);
	check_total++;
	if (actual != expected) begin
		error_count++;
		$display("FAIL %s: expected %0d cycles, actual %0d", cur_test, expected, actual);
	end
endtask

task automatic report_hang(input string what);
	error_count++;
	$display("ERROR %s: timed out, %s", cur_test, what);
endtask

task automatic begin_test(input string name);
	cur_test = name;
	test_mark = error_count;
endtask

task automatic end_test();
	tests_run++;
	if (error_count == test_mark) begin
		$display("test %s: ok", cur_test);
	end else begin
		tests_failed++;
		$display("test %s: %0d errors", cur_test, error_count - test_mark);
	end
endtask

// sample n sits at floor(n*k*2^20/N) mod 2^20
function automatic twdl_pkg::phase_t model_phase(input int n, input int k, input int big_n);
	longint turns;
	turns = longint'(n) * longint'(k) * (longint'(1) << `TWDL_W_PHASE);
	return twdl_pkg::phase_t'((turns / big_n) % (longint'(1) << `TWDL_W_PHASE));
endfunction

function automatic int round_to_int(input real x);
	if (x >= 0.0)
		return $rtoi(x + 0.5);
	return -$rtoi(0.5 - x);
endfunction

function automatic twdl_pkg::sample_t expect_real(input twdl_pkg::phase_t p);
	real ang;
	ang = TWO_PI * real'(p) / real'(longint'(1) << `TWDL_W_PHASE);
	return twdl_pkg::sample_t'(round_to_int(`TWDL_AMP * $cos(ang)));
endfunction

// conjugate, so the sine comes out negated
function automatic twdl_pkg::sample_t expect_imag(input twdl_pkg::phase_t p);
	real ang;
	ang = TWO_PI * real'(p) / real'(longint'(1) << `TWDL_W_PHASE);
	return twdl_pkg::sample_t'(round_to_int(-`TWDL_AMP * $sin(ang)));
endfunction

`endif

//--- testbench/twdl_tb.sv
// ----------------------------------------------------------
// clock, reset, DUT, LFSR and directed twiddle tests
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "twdl_consts.svh"

module twdl_tb;

	logic clk;
	logic rst_n;
	logic cfg_req;
	twdl_pkg::twdl_op_e cfg_op;
	logic [`TWDL_W_PHASE-1:0] cfg_data;
	logic cfg_ack;
	logic out_valid;
	twdl_pkg::sample_t dout_real;
	twdl_pkg::sample_t dout_imag;

	// captured output stream
	twdl_pkg::sample_t got_re [0:63];
	twdl_pkg::sample_t got_im [0:63];
	logic [15:0] lfsr;

	`include "twdl_tb_checks.svh"

	twdl_gen_top dut_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.cfg_req   (cfg_req),
		.cfg_op    (cfg_op),
		.cfg_data  (cfg_data),
		.cfg_ack   (cfg_ack),
		.out_valid (out_valid),
		.dout_real (dout_real),
		.dout_imag (dout_imag)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// fibonacci, taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// one lfsr step per bit taken
	task automatic draw_bits(input int nbits, output int value);
		value = 0;
		for (int i = 0; i < nbits; i++) begin
			lfsr = lfsr_next(lfsr);
			value = (value << 1) | int'(lfsr[0]);
		end
	endtask

	// ------------------------------------------------------------
	// bus helpers, all entered and left 5 ns after an edge
	// ------------------------------------------------------------
	task automatic cfg_write(input twdl_pkg::twdl_op_e op, input int data,
			output int rise_cyc, output int fall_cyc);
		// no new req while ack still up
		check_flag(1'b0, cfg_ack);
		cfg_op = op;
		cfg_data = data[`TWDL_W_PHASE-1:0];
		cfg_req = 1'b1;
		rise_cyc = 0;
		do begin
			@(posedge clk);
			#5;
			rise_cyc++;
		end while (!cfg_ack && rise_cyc < 20);
		if (!cfg_ack)
			report_hang("cfg_ack never rose");
		cfg_req = 1'b0;
		fall_cyc = 0;
		do begin
			@(posedge clk);
			#5;
			fall_cyc++;
		end while (cfg_ack && fall_cyc < 20);
		if (cfg_ack)
			report_hang("cfg_ack never fell");
	endtask

	task automatic cfg_put(input twdl_pkg::twdl_op_e op, input int data);
		int rise;
		int fall;
		cfg_write(op, data, rise, fall);
	endtask

	// pipe is empty once out_valid stays low for a full pipe length
	task automatic wait_drain();
		int cyc;
		int quiet;
		cyc = 0;
		quiet = 0;
		while (quiet <= `TWDL_LATENCY && cyc < 80) begin
			@(posedge clk);
			#5;
			cyc++;
			if (out_valid)
				quiet = 0;
			else
				quiet++;
		end
		if (quiet <= `TWDL_LATENCY)
			report_hang("out_valid did not settle low after halt");
	endtask

	// halt, drain, program step for ratio k/N, run
	task automatic start_stream(input int big_n, input int k);
		longint scaled;
		scaled = longint'(k) << `TWDL_W_PHASE;
		cfg_put(twdl_pkg::OP_HALT, 0);
		wait_drain();
		cfg_put(twdl_pkg::OP_SET_DEN, big_n);
		cfg_put(twdl_pkg::OP_SET_QUO, int'(scaled / big_n));
		cfg_put(twdl_pkg::OP_SET_REM, int'(scaled % big_n));
		cfg_put(twdl_pkg::OP_RUN, 0);
	endtask

	task automatic collect(input int n);
		int got;
		int cyc;
		got = 0;
		cyc = 0;
		while (got < n && cyc < n + 40) begin
			@(posedge clk);
			#5;
			cyc++;
			if (out_valid) begin
				got_re[got] = dout_real;
				got_im[got] = dout_imag;
				got++;
			end
		end
		if (got < n)
			report_hang("fewer samples than expected on out_valid");
	endtask

	task automatic match_model(input int n_cnt, input int k, input int big_n);
		twdl_pkg::phase_t p;
		for (int i = 0; i < n_cnt; i++) begin
			p = model_phase(i, k, big_n);
			check_sample(expect_real(p), got_re[i]);
			check_sample(expect_imag(p), got_im[i]);
		end
	endtask

	// ------------------------------------------------------------
	// directed tests
	// ------------------------------------------------------------
	task automatic test_idle_after_reset();
		begin_test("idle_after_reset");
		for (int i = 0; i < 30; i++) begin
			check_flag(1'b0, cfg_ack);
			check_flag(1'b0, out_valid);
			@(posedge clk);
			#5;
		end
		end_test();
	endtask

	task automatic test_handshake();
		int rise;
		int fall;
		twdl_pkg::twdl_op_e ops [5];
		begin_test("handshake");
		ops = '{twdl_pkg::OP_SET_DEN, twdl_pkg::OP_SET_QUO, twdl_pkg::OP_SET_REM,
			twdl_pkg::OP_RUN, twdl_pkg::OP_HALT};
		for (int i = 0; i < 5; i++) begin
			// den first, so run never sees a zero modulus
			cfg_write(ops[i], (i == 0) ? 1200 : 0, rise, fall);
			check_count(1, rise);
			check_count(1, fall);
		end
		end_test();
	endtask

	task automatic test_carry_1200();
		begin_test("carry_1200");
		// remainder 976 of 1200, carries often
		start_stream(1200, 1);
		collect(64);
		match_model(64, 1, 1200);
		end_test();
	endtask

	task automatic test_zero_step();
		begin_test("zero_step");
		start_stream(1200, 0);
		collect(32);
		for (int i = 0; i < 32; i++) begin
			check_sample(twdl_pkg::sample_t'(`TWDL_AMP), got_re[i]);
			check_sample(twdl_pkg::sample_t'(0), got_im[i]);
		end
		end_test();
	endtask

	task automatic test_restart_300();
		begin_test("restart_300");
		start_stream(300, 7);
		collect(10);
		cfg_put(twdl_pkg::OP_HALT, 0);
		wait_drain();
		// accumulator cleared while halted
		cfg_put(twdl_pkg::OP_RUN, 0);
		collect(33);
		check_sample(twdl_pkg::sample_t'(`TWDL_AMP), got_re[0]);
		check_sample(twdl_pkg::sample_t'(0), got_im[0]);
		match_model(33, 7, 300);
		end_test();
	endtask

	task automatic test_random_75();
		int v;
		int k;
		begin_test("random_75");
		for (int t = 0; t < 5; t++) begin
			draw_bits(7, v);
			k = (v % 74) + 1;
			start_stream(75, k);
			collect(40);
			match_model(40, k, 75);
		end
		end_test();
	endtask

	initial begin
		rst_n = 1'b0;
		cfg_req = 1'b0;
		cfg_op = twdl_pkg::OP_HALT;
		cfg_data = '0;
		lfsr = 16'd56846;
		error_count = 0;
		check_total = 0;
		tests_run = 0;
		tests_failed = 0;
		repeat (16) @(posedge clk);
		#5;
		rst_n = 1'b1;
		test_idle_after_reset();
		test_handshake();
		test_carry_1200();
		test_zero_step();
		test_restart_300();
		test_random_75();
		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, check_total, error_count);
		if (error_count == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

//--- filelist.f
+incdir+logic
+incdir+testbench
logic/twdl_pkg.sv
logic/twdl_cfg_regs.sv
logic/cordic_rotator.sv
logic/coeff_twdl.sv
logic/twdl_gen_top.sv
testbench/twdl_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the twiddle generator testbench with Verilator, run it, scan the log
cd "$(dirname "$0")" || exit 1
set -o pipefail
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module twdl_tb -f filelist.f -o twdl_sim \
	&& ./obj_dir/twdl_sim | tee sim.log \
	|| { echo "build or simulation error"; exit 1; }
grep -q "SOME TESTS FAILED" sim.log && { echo "simulation reported failures"; exit 1; } \
	|| echo "simulation clean"
